/* sim.f */
common/alu_pkg.sv
alu/alu.sv
alu/status_flags.sv
rtl/reg_file.sv
rtl/sb_arbiter.sv
rtl/datapath_top.sv
tb/datapath_checker.sv
tb/datapath_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the datapath testbench with Verilator
# the run counts as failed on a bad exit status or a fail line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=datapath_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module datapath_tb -o "$BIN" -f sim.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "testbench reported failure, see $LOG"
    exit 1
fi

exit 0

/* tb/datapath_tb.sv */
// testbench for the datapath slice
// table of micro-operations, expected state from a reference model,
// one entry applied per clock and checked after its write-back edge
`timescale 1ns/1ps
`default_nettype none

module datapath_tb
    import alu_pkg::*;
();

    localparam int N_TESTS        = 21;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = N_TESTS + RESET_CYCLES + 20;

    // one table row with expected fields filled in by the model
    typedef struct packed {
        uop_t  uop;
        byte_t db;
        byte_t adl;
        byte_t sb_ext;
        regs_t exp_regs;
        byte_t exp_add;
        logic  exp_conflict;
    } entry_t;

    logic   clk;
    logic   reset_n;
    uop_t   uop;
    byte_t  db;
    byte_t  adl;
    byte_t  sb_ext;
    regs_t  regs;
    byte_t  add_out;
    logic   sb_conflict;

    entry_t table_e [N_TESTS];
    string  names [N_TESTS];
    int     test_errors [N_TESTS];
    int     n_built;
    uop_t   idle_uop;

    // model state after the last predicted entry
    regs_t  m_regs;
    byte_t  m_add;

    datapath_top dut_i (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_uop         (uop),
        .i_db          (db),
        .i_adl         (adl),
        .i_sb_ext      (sb_ext),
        .o_regs        (regs),
        .o_add         (add_out),
        .o_sb_conflict (sb_conflict)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // upd is {nz, c, v}
    function automatic uop_t build_uop(a_sel_e asel, b_sel_e bsel, alu_op_e op, cin_sel_e cin,
                                       sb_src_t req, reg_sel_e rsrc, reg_sel_e rdst,
                                       logic [2:0] upd);
        return '{a_sel: asel, b_sel: bsel, alu_op: op, cin_sel: cin, sb_req: req,
                 sb_reg: rsrc, wr_reg: rdst, upd_nz: upd[2], upd_c: upd[1], upd_v: upd[0]};
    endfunction

    task automatic predict_entry(int idx);
        uop_t  u;
        byte_t sb_val;
        byte_t a_in;
        byte_t b_in;
        byte_t res;
        logic  cin;
        logic  cout;
        logic  vout;
        int    su;
        int    ss;
        u = table_e[idx].uop;
        // register beats add beats external and an idle bus reads high
        if (u.sb_req[SB_BIT_REG])
            sb_val = (u.sb_reg == REG_A) ? m_regs.a : (u.sb_reg == REG_X) ? m_regs.x :
                     (u.sb_reg == REG_Y) ? m_regs.y : 8'hff;
        else if (u.sb_req[SB_BIT_ADD])
            sb_val = m_add;
        else if (u.sb_req[SB_BIT_EXT])
            sb_val = table_e[idx].sb_ext;
        else
            sb_val = 8'hff;
        a_in = (u.a_sel == A_ZERO) ? 8'h00 : (u.a_sel == A_SB) ? sb_val : 8'hff;
        case (u.b_sel)
            B_DB:    b_in = table_e[idx].db;
            B_DB_N:  b_in = ~table_e[idx].db;
            B_ADL:   b_in = table_e[idx].adl;
            default: b_in = 8'hff;
        endcase
        case (u.cin_sel)
            CIN_ONE:  cin = 1'b1;
            CIN_FLAG: cin = m_regs.p_c;
            default:  cin = 1'b0;
        endcase
        // unsigned sum gives carry and a signed sum out of range gives overflow
        su   = int'(a_in) + int'(b_in) + int'(cin);
        ss   = int'($signed(a_in)) + int'($signed(b_in)) + int'(cin);
        cout = 1'b0;
        vout = 1'b0;
        case (u.alu_op)
            OP_SUM:
            begin
                res  = byte_t'(su);
                cout = (su > 255);
                vout = (ss > 127) || (ss < -128);
            end
            OP_AND: res = a_in & b_in;
            OP_EOR: res = a_in ^ b_in;
            OP_OR:  res = a_in | b_in;
            OP_SR:
            begin
                res  = {cin, a_in[7:1]};
                cout = a_in[0];
            end
            default: res = 8'h00;
        endcase
        case (u.wr_reg)
            REG_A:   m_regs.a = res;
            REG_X:   m_regs.x = res;
            REG_Y:   m_regs.y = res;
            default: ;
        endcase
        if (u.upd_nz)
        begin
            m_regs.p_n = res[7];
            m_regs.p_z = (res == 8'h00);
        end
        if (u.upd_c)
            m_regs.p_c = cout;
        if (u.upd_v)
            m_regs.p_v = vout;
        m_add = res;
        table_e[idx].exp_regs     = m_regs;
        table_e[idx].exp_add      = res;
        table_e[idx].exp_conflict = ($countones(u.sb_req) > 1);
    endtask

    task automatic add_entry(string name, uop_t u, byte_t d, byte_t a, byte_t e);
        table_e[n_built]     = '0;
        table_e[n_built].uop = u;
        table_e[n_built].db  = d;
        table_e[n_built].adl = a;
        table_e[n_built].sb_ext = e;
        names[n_built]       = name;
        test_errors[n_built] = 0;
        predict_entry(n_built);
        n_built++;
    endtask

    task automatic build_table();
        m_regs  = '0;
        m_add   = '0;
        n_built = 0;
        add_entry("idle_after_reset", idle_uop, 8'h00, 8'h00, 8'h00);
        // load A and then add with the C flag across sign and carry limits
        add_entry("lda_db_7f", build_uop(A_ZERO, B_DB, OP_SUM, CIN_ZERO, 3'b000,
                  REG_NONE, REG_A, 3'b100), 8'h7f, 8'h00, 8'h00);
        add_entry("adc_7f_01", build_uop(A_SB, B_DB, OP_SUM, CIN_FLAG, 3'b100,
                  REG_A, REG_A, 3'b111), 8'h01, 8'h00, 8'h00);
        add_entry("ldx_db_ff", build_uop(A_ZERO, B_DB, OP_SUM, CIN_ZERO, 3'b000,
                  REG_NONE, REG_X, 3'b100), 8'hff, 8'h00, 8'h00);
        add_entry("adc_ff_01", build_uop(A_SB, B_DB, OP_SUM, CIN_FLAG, 3'b100,
                  REG_X, REG_X, 3'b111), 8'h01, 8'h00, 8'h00);
        add_entry("adc_carry_flag", build_uop(A_SB, B_DB, OP_SUM, CIN_FLAG, 3'b100,
                  REG_X, REG_Y, 3'b111), 8'h10, 8'h00, 8'h00);
        // subtract db from the external input on sb
        for (int i = 0; i < 4; i++)
            add_entry($sformatf("sbc_random_%0d", i), build_uop(A_SB, B_DB_N, OP_SUM,
                      CIN_ONE, 3'b001, REG_NONE, REG_A, 3'b111),
                      8'($urandom), 8'h00, 8'($urandom));
        // logic ops leave C and V alone
        add_entry("and_reg_adl", build_uop(A_SB, B_ADL, OP_AND, CIN_ZERO, 3'b100,
                  REG_A, REG_X, 3'b100), 8'h00, 8'($urandom), 8'h00);
        add_entry("eor_reg_adl", build_uop(A_SB, B_ADL, OP_EOR, CIN_ZERO, 3'b100,
                  REG_X, REG_Y, 3'b100), 8'h00, 8'hff, 8'h00);
        add_entry("ora_reg_adl", build_uop(A_SB, B_ADL, OP_OR, CIN_ZERO, 3'b100,
                  REG_Y, REG_A, 3'b100), 8'h00, 8'($urandom), 8'h00);
        // shift right with bit 0 out to C and carry in to bit 7
        add_entry("lda_db_81", build_uop(A_ZERO, B_DB, OP_SUM, CIN_ZERO, 3'b000,
                  REG_NONE, REG_A, 3'b100), 8'h81, 8'h00, 8'h00);
        add_entry("sr_cin_zero", build_uop(A_SB, B_ONES, OP_SR, CIN_ZERO, 3'b100,
                  REG_A, REG_A, 3'b110), 8'h00, 8'h00, 8'h00);
        add_entry("sr_cin_flag", build_uop(A_SB, B_ONES, OP_SR, CIN_FLAG, 3'b100,
                  REG_A, REG_A, 3'b110), 8'h00, 8'h00, 8'h00);
        // sb sharing
        add_entry("add_feedback", build_uop(A_SB, B_DB, OP_SUM, CIN_ZERO, 3'b010,
                  REG_NONE, REG_X, 3'b100), 8'h01, 8'h00, 8'h00);
        add_entry("ext_only", build_uop(A_SB, B_DB, OP_SUM, CIN_ZERO, 3'b001,
                  REG_NONE, REG_Y, 3'b100), 8'h00, 8'h00, 8'h5a);
        add_entry("reg_ext_conflict", build_uop(A_SB, B_DB, OP_SUM, CIN_ZERO, 3'b101,
                  REG_Y, REG_A, 3'b100), 8'h00, 8'h00, 8'h33);
        // leaves every register nonzero and Z clear before the idle entry
        add_entry("no_request", build_uop(A_SB, B_DB, OP_SUM, CIN_ZERO, 3'b000,
                  REG_NONE, REG_X, 3'b111), 8'h02, 8'h00, 8'h00);
        add_entry("idle_no_write", idle_uop, 8'h00, 8'h00, 8'h00);
    endtask

    task automatic drive_inputs(uop_t u, byte_t d, byte_t a, byte_t e);
        uop    <= u;
        db     <= d;
        adl    <= a;
        sb_ext <= e;
    endtask

    task automatic expect_value(int idx, string sig, logic [7:0] got, logic [7:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] t=%0t %s: %s = %02h, expected %02h",
                     $time, names[idx], sig, got, exp);
            test_errors[idx]++;
        end
    endtask

    task automatic check_entry(int idx);
        expect_value(idx, "o_regs.a", regs.a, table_e[idx].exp_regs.a);
        expect_value(idx, "o_regs.x", regs.x, table_e[idx].exp_regs.x);
        expect_value(idx, "o_regs.y", regs.y, table_e[idx].exp_regs.y);
        expect_value(idx, "o_regs.p_n", {7'd0, regs.p_n}, {7'd0, table_e[idx].exp_regs.p_n});
        expect_value(idx, "o_regs.p_v", {7'd0, regs.p_v}, {7'd0, table_e[idx].exp_regs.p_v});
        expect_value(idx, "o_regs.p_z", {7'd0, regs.p_z}, {7'd0, table_e[idx].exp_regs.p_z});
        expect_value(idx, "o_regs.p_c", {7'd0, regs.p_c}, {7'd0, table_e[idx].exp_regs.p_c});
        expect_value(idx, "o_add", add_out, table_e[idx].exp_add);
        $display("test %0d %s: %s", idx, names[idx], (test_errors[idx] == 0) ? "ok" : "failed");
    endtask

    initial
    begin
        int unsigned seed;
        int          total_errors;
        int          n_failed;
        seed     = $urandom(74);
        idle_uop = build_uop(A_ONES, B_ONES, OP_NONE, CIN_ZERO, 3'b000,
                             REG_NONE, REG_NONE, 3'b000);
        reset_n  = 1'b0;
        uop      = idle_uop;
        db       = '0;
        adl      = '0;
        sb_ext   = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        // one idle cycle out of reset
        @(posedge clk);
        // entry k goes in while entry k-1 is written back
        for (int k = 0; k <= N_TESTS; k++)
        begin
            @(posedge clk);
            if (k < N_TESTS)
                drive_inputs(table_e[k].uop, table_e[k].db, table_e[k].adl, table_e[k].sb_ext);
            else
                drive_inputs(idle_uop, 8'h00, 8'h00, 8'h00);
            #1;
            if (k < N_TESTS)
                expect_value(k, "o_sb_conflict", {7'd0, sb_conflict},
                             {7'd0, table_e[k].exp_conflict});
            if (k > 0)
                check_entry(k - 1);
        end
        total_errors = 0;
        n_failed     = 0;
        for (int k = 0; k < N_TESTS; k++)
        begin
            total_errors += test_errors[k];
            if (test_errors[k] != 0)
                n_failed++;
        end
        $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
                 N_TESTS, N_TESTS - n_failed, n_failed, total_errors);
        if (total_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // run limit
    initial
    begin
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the test table did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/datapath_checker.sv */
// sb bus and reset checks for the datapath top level
// bound into datapath_top
`timescale 1ns/1ps
`default_nettype none

module datapath_checker
    import alu_pkg::*;
(
    input wire       i_clk,
    input wire       i_reset_n,
    input sb_src_t   i_req,
    input sb_grant_e i_grant,
    input wire       i_conflict,
    input byte_t     i_add
);

    // first cycle out of reset is conflict free
    conflict_after_reset: assert property (@(posedge i_clk) $rose(i_reset_n) |-> !i_conflict)
    else
        $error("sb conflict raised in the first cycle after reset");

    // any request must own the bus
    grant_on_request: assert property (@(posedge i_clk) disable iff (!i_reset_n)
                                       (i_req != '0) |-> (i_grant != SB_NONE))
    else
        $error("sb request pending with no grant");

    // add register cleared by reset
    add_after_reset: assert property (@(posedge i_clk) $rose(i_reset_n) |-> (i_add == '0))
    else
        $error("add register not zero in the first cycle after reset");

endmodule

bind datapath_top datapath_checker checker_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_req      (sb_req),
    .i_grant    (sb_grant),
    .i_conflict (o_sb_conflict),
    .i_add      (o_add)
);

`default_nettype wire

/* rtl/datapath_top.sv */
// datapath slice top level
// ALU, register file, sb arbiter and status flags,
// driven by one micro-operation per clock
`timescale 1ns/1ps
`default_nettype none

module datapath_top
    import alu_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset_n,

    input  uop_t  i_uop,
    input  byte_t i_db,
    input  byte_t i_adl,
    input  byte_t i_sb_ext,

    output regs_t o_regs,
    output byte_t o_add,
    output logic  o_sb_conflict
);

    byte_t     sb;
    byte_t     reg_sb_value;
    byte_t     reg_a;
    byte_t     reg_x;
    byte_t     reg_y;
    sb_src_t   sb_req;
    sb_grant_e sb_grant;
    logic      reg_req;
    logic      carry_in;
    logic      acr_hold;
    logic      avr_hold;
    logic      flag_n;
    logic      flag_v;
    logic      flag_z;
    logic      flag_c;

    // register file request replaces its bit of the mask
    assign sb_req = {reg_req, i_uop.sb_req[SB_BIT_ADD], i_uop.sb_req[SB_BIT_EXT]};

    // carry in choice
    assign carry_in = (i_uop.cin_sel == CIN_FLAG) ? flag_c : (i_uop.cin_sel == CIN_ONE);

    alu alu_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_a_sel    (i_uop.a_sel),
        .i_b_sel    (i_uop.b_sel),
        .i_op       (i_uop.alu_op),
        .i_carry_in (carry_in),
        .i_sb       (sb),
        .i_db       (i_db),
        .i_adl      (i_adl),
        .o_add      (o_add),
        .o_acr      (),
        .o_avr      (),
        .o_acr_hold (acr_hold),
        .o_avr_hold (avr_hold)
    );

    reg_file reg_file_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_sb_reg   (i_uop.sb_reg),
        .i_wr_reg   (i_uop.wr_reg),
        .i_add      (o_add),
        .i_sb_req   (i_uop.sb_req[SB_BIT_REG]),
        .o_req      (reg_req),
        .o_sb_value (reg_sb_value),
        .o_a        (reg_a),
        .o_x        (reg_x),
        .o_y        (reg_y)
    );

    sb_arbiter sb_arbiter_i (
        .i_req       (sb_req),
        .i_reg_value (reg_sb_value),
        .i_add       (o_add),
        .i_ext       (i_sb_ext),
        .o_sb        (sb),
        .o_grant     (sb_grant),
        .o_conflict  (o_sb_conflict)
    );

    status_flags status_flags_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_add      (o_add),
        .i_acr_hold (acr_hold),
        .i_avr_hold (avr_hold),
        .i_upd_nz   (i_uop.upd_nz),
        .i_upd_c    (i_uop.upd_c),
        .i_upd_v    (i_uop.upd_v),
        .o_n        (flag_n),
        .o_v        (flag_v),
        .o_z        (flag_z),
        .o_c        (flag_c)
    );

    // visible state
    assign o_regs = '{a: reg_a, x: reg_x, y: reg_y,
                      p_n: flag_n, p_v: flag_v, p_z: flag_z, p_c: flag_c};

endmodule

`default_nettype wire

/* rtl/sb_arbiter.sv */
// sb bus sharing
// fixed priority grant: register file, then add, then external input
// conflict flag when more than one source asks in the same cycle
`timescale 1ns/1ps
`default_nettype none

module sb_arbiter
    import alu_pkg::*;
(
    input  sb_src_t   i_req,
    input  byte_t     i_reg_value,
    input  byte_t     i_add,
    input  byte_t     i_ext,

    output byte_t     o_sb,
    output sb_grant_e o_grant,
    output logic      o_conflict
);

    logic [1:0] req_count;

    // priority select
    always_comb
    begin
        if (i_req[SB_BIT_REG])
            o_grant = SB_REG;
        else if (i_req[SB_BIT_ADD])
            o_grant = SB_ADD;
        else if (i_req[SB_BIT_EXT])
            o_grant = SB_EXT;
        else
            o_grant = SB_NONE;
    end

    // granted value, idle bus floats high
    always_comb
    begin
        case (o_grant)
            SB_REG:  o_sb = i_reg_value;
            SB_ADD:  o_sb = i_add;
            SB_EXT:  o_sb = i_ext;
            default: o_sb = BYTE_ONES;
        endcase
    end

    // count requesters
    always_comb
    begin
        req_count = '0;
        for (int i = 0; i < SB_SOURCES; i++)
            req_count = req_count + {1'b0, i_req[i]};
        o_conflict = (req_count > 2'd1);
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// accumulator, X and Y registers
// offers one register to the sb bus and writes the add
// result back one rising edge after the micro-operation
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import alu_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_reset_n,

    input  reg_sel_e i_sb_reg,
    input  reg_sel_e i_wr_reg,
    input  byte_t    i_add,
    input  wire      i_sb_req,

    output logic     o_req,
    output byte_t    o_sb_value,
    output byte_t    o_a,
    output byte_t    o_x,
    output byte_t    o_y
);

    reg_sel_e wr_pend;

    // request towards the arbiter
    assign o_req = i_sb_req;

    // sb candidate value
    always_comb
    begin
        case (i_sb_reg)
            REG_A:   o_sb_value = o_a;
            REG_X:   o_sb_value = o_x;
            REG_Y:   o_sb_value = o_y;
            default: o_sb_value = BYTE_ONES;
        endcase
    end

    // destination held with add at the falling edge
    always_ff @(negedge i_clk)
    begin
        if (!i_reset_n)
            wr_pend <= REG_NONE;
        else
            wr_pend <= i_wr_reg;
    end

    // write back
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_a <= '0;
            o_x <= '0;
            o_y <= '0;
        end
        else
        begin
            case (wr_pend)
                REG_A:   o_a <= i_add;
                REG_X:   o_x <= i_add;
                REG_Y:   o_y <= i_add;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* alu/status_flags.sv */
// processor status flags N, V, Z and C
// update selects are held at the falling edge with the add result,
// the flags change on the following rising edge
`timescale 1ns/1ps
`default_nettype none

module status_flags
    import alu_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset_n,

    input  byte_t i_add,
    input  wire   i_acr_hold,
    input  wire   i_avr_hold,

    input  wire   i_upd_nz,
    input  wire   i_upd_c,
    input  wire   i_upd_v,

    output logic  o_n,
    output logic  o_v,
    output logic  o_z,
    output logic  o_c
);

    logic pend_nz;
    logic pend_c;
    logic pend_v;

    // pending update selects, aligned with the add register
    always_ff @(negedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pend_nz <= 1'b0;
            pend_c  <= 1'b0;
            pend_v  <= 1'b0;
        end
        else
        begin
            pend_nz <= i_upd_nz;
            pend_c  <= i_upd_c;
            pend_v  <= i_upd_v;
        end
    end

    // write back on the next rising edge
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_n <= 1'b0;
            o_v <= 1'b0;
            o_z <= 1'b0;
            o_c <= 1'b0;
        end
        else
        begin
            if (pend_nz)
            begin
                o_n <= i_add[7];
                o_z <= (i_add == '0);
            end
            // carry also feeds CIN_FLAG at the top
            if (pend_c)
                o_c <= i_acr_hold;
            if (pend_v)
                o_v <= i_avr_hold;
        end
    end

endmodule

`default_nettype wire

/* alu/alu.sv */
// ALU of the datapath slice
// A and B input selection, sum, and, eor, or and shift right,
// carry and overflow outputs, and the adder hold register
// which latches the result on the falling clock edge
// decimal mode and half carry are not implemented
`timescale 1ns/1ps
`default_nettype none

module alu
    import alu_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_reset_n,

    input  a_sel_e   i_a_sel,
    input  b_sel_e   i_b_sel,
    input  alu_op_e  i_op,
    input  wire      i_carry_in,

    input  byte_t    i_sb,
    input  byte_t    i_db,
    input  byte_t    i_adl,

    output byte_t    o_add,
    output logic     o_acr,
    output logic     o_avr,
    output logic     o_acr_hold,
    output logic     o_avr_hold
);

    byte_t      in_a;
    byte_t      in_b;
    byte_t      alu_res;
    logic [8:0] sum;

    // A input, ones by default as on the real chip
    always_comb
    begin
        case (i_a_sel)
            A_ZERO:  in_a = '0;
            A_SB:    in_a = i_sb;
            default: in_a = BYTE_ONES;
        endcase
    end

    // B input, db can come in inverted for subtraction
    always_comb
    begin
        case (i_b_sel)
            B_DB:    in_b = i_db;
            B_DB_N:  in_b = ~i_db;
            B_ADL:   in_b = i_adl;
            default: in_b = BYTE_ONES;
        endcase
    end

    // 9 bit sum, bit 8 is the carry out
    assign sum = {1'b0, in_a} + {1'b0, in_b} + {8'd0, i_carry_in};

    always_comb
    begin
        alu_res = '0;
        o_acr   = 1'b0;
        o_avr   = 1'b0;
        case (i_op)
            OP_SUM:
            begin
                alu_res = sum[7:0];
                o_acr   = sum[8];
                // operands agree in sign, result does not
                o_avr   = (in_a[7] == in_b[7]) && (in_a[7] != sum[7]);
            end
            OP_AND: alu_res = in_a & in_b;
            OP_EOR: alu_res = in_a ^ in_b;
            OP_OR:  alu_res = in_a | in_b;
            OP_SR:
            begin
                // carry in rotates into bit 7
                alu_res = {i_carry_in, in_a[7:1]};
                o_acr   = in_a[0];
            end
            default: alu_res = '0;
        endcase
    end

    // adder hold register, falling edge
    // carry and overflow travel with the result
    always_ff @(negedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_add      <= '0;
            o_acr_hold <= 1'b0;
            o_avr_hold <= 1'b0;
        end
        else
        begin
            o_add      <= alu_res;
            o_acr_hold <= o_acr;
            o_avr_hold <= o_avr;
        end
    end

endmodule

`default_nettype wire

/* common/alu_pkg.sv */
// shared types for the 6502 style datapath slice
// bus byte type, ALU and bus select encodings,
// the per-cycle micro-operation word and the visible register state
`default_nettype none

package alu_pkg;

    // all datapath buses are one byte wide
    typedef logic [7:0] byte_t;

    // value of a bus that nobody drives
    localparam byte_t BYTE_ONES = 8'hff;

    // sb request mask layout
    localparam int SB_SOURCES = 3;
    localparam int SB_BIT_EXT = 0;
    localparam int SB_BIT_ADD = 1;
    localparam int SB_BIT_REG = 2;

    typedef logic [SB_SOURCES-1:0] sb_src_t;

    // one operation per cycle at most
    typedef enum logic [2:0] {
        OP_NONE,
        OP_SUM,
        OP_AND,
        OP_EOR,
        OP_OR,
        OP_SR
    } alu_op_e;

    // A input source, all ones when nothing loads it
    typedef enum logic [1:0] {
        A_ZERO,
        A_SB,
        A_ONES
    } a_sel_e;

    // B input source
    typedef enum logic [1:0] {
        B_DB,
        B_DB_N,
        B_ADL,
        B_ONES
    } b_sel_e;

    // carry in, CIN_FLAG takes the stored C flag
    typedef enum logic [1:0] {
        CIN_ZERO,
        CIN_ONE,
        CIN_FLAG
    } cin_sel_e;

    // source that owns sb this cycle
    typedef enum logic [1:0] {
        SB_NONE,
        SB_EXT,
        SB_ADD,
        SB_REG
    } sb_grant_e;

    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y,
        REG_NONE
    } reg_sel_e;

    // one micro-operation, applied for exactly one clock
    typedef struct packed {
        a_sel_e   a_sel;
        b_sel_e   b_sel;
        alu_op_e  alu_op;
        cin_sel_e cin_sel;
        sb_src_t  sb_req;
        reg_sel_e sb_reg;
        reg_sel_e wr_reg;
        logic     upd_nz;
        logic     upd_c;
        logic     upd_v;
    } uop_t;

    // programmer visible register state
    typedef struct packed {
        byte_t a;
        byte_t x;
        byte_t y;
        logic  p_n;
        logic  p_v;
        logic  p_z;
        logic  p_c;
    } regs_t;

endpackage

`default_nettype wire
